// File: testbench/laneAlignVectors.txt
// Columns in hex: tag inData right rotate keep expectedOutData
// Tags: 1 rotation, 2 keep mask, 3 overflow, 4 random drain
// Rotation by every amount, right R matches left 8-R
1 8877665544332211 0 0 8 8877665544332211
1 8877665544332211 0 1 8 7766554433221188
1 8877665544332211 0 2 8 6655443322118877
1 8877665544332211 0 3 8 5544332211887766
1 8877665544332211 0 4 8 4433221188776655
1 8877665544332211 0 5 8 3322118877665544
1 8877665544332211 0 6 8 2211887766554433
1 8877665544332211 0 7 8 1188776655443322
1 8877665544332211 1 0 8 8877665544332211
1 8877665544332211 1 1 8 1188776655443322
1 8877665544332211 1 2 8 2211887766554433
1 8877665544332211 1 3 8 3322118877665544
1 8877665544332211 1 4 8 4433221188776655
1 8877665544332211 1 5 8 5544332211887766
1 8877665544332211 1 6 8 6655443322118877
1 8877665544332211 1 7 8 7766554433221188
// Keep counts 0 to 8
2 f0e1d2c3b4a59687 0 2 0 0000000000000000
2 f0e1d2c3b4a59687 0 2 1 00000000000000e1
2 f0e1d2c3b4a59687 0 2 2 000000000000f0e1
2 f0e1d2c3b4a59687 0 2 3 000000000087f0e1
2 f0e1d2c3b4a59687 0 2 4 000000009687f0e1
2 f0e1d2c3b4a59687 1 3 5 000000f0e1d2c3b4
2 f0e1d2c3b4a59687 1 3 6 000087f0e1d2c3b4
2 f0e1d2c3b4a59687 1 3 7 009687f0e1d2c3b4
2 f0e1d2c3b4a59687 1 3 8 a59687f0e1d2c3b4
// Six words with drain low, the last two are dropped
3 0123456789abcdef 0 0 8 0123456789abcdef
3 0123456789abcdef 0 1 8 23456789abcdef01
3 0123456789abcdef 1 1 8 ef0123456789abcd
3 0123456789abcdef 0 4 4 0000000001234567
3 0123456789abcdef 0 2 8 456789abcdef0123
3 0123456789abcdef 1 2 8 cdef0123456789ab
// Stream under random drain
4 1f2e3d4c5b6a7988 0 3 8 4c5b6a79881f2e3d
4 1f2e3d4c5b6a7988 1 3 8 6a79881f2e3d4c5b
4 1f2e3d4c5b6a7988 0 0 6 00003d4c5b6a7988
4 1f2e3d4c5b6a7988 1 7 8 2e3d4c5b6a79881f
4 0123456789abcdef 0 5 3 0000000000456789
4 0123456789abcdef 1 4 8 89abcdef01234567
4 f0e1d2c3b4a59687 0 6 8 9687f0e1d2c3b4a5
4 f0e1d2c3b4a59687 1 6 2 000000000000f0e1

// File: project.f
verilog/laneAlignPkg.sv
verilog/laneFifoIf.sv
verilog/laneRotator.sv
verilog/laneBuffer.sv
verilog/laneEmitter.sv
verilog/laneAlignTop.sv
testbench/laneAlign_assertions.sv
testbench/laneAlignTb.sv

// File: testbench/laneAlignTb.sv
////////////////////
// Lane alignment testbench
// Vector-driven stimulus, drain patterns and an output scoreboard
////////////////////
`default_nettype none

module laneAlignTb;
  timeunit 1ns;
  timeprecision 100ps;

  import laneAlignPkg::*;

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 8;
  // Columns of one vector line: tag, inData, right, rotate, keep, expected
  localparam int VecFields = 6;
  localparam int MaxVectors = 64;

  logic clk;
  logic rstN;
  logic inValid;
  wordT inData;
  logic right;
  rotateT rotate;
  keepT inKeep;
  logic drain;
  logic outValid;
  wordT outData;
  logic overflow;

  // Vector fields in file order, six entries per line
  wordT vecMem [VecFields*MaxVectors];
  int vectorCount = 0;
  int errorCount = 0;
  int checkCount = 0;
  logic [31:0] lfsrState;
  // Words sent and not yet seen at the output, oldest first
  wordT expQ [$];

  laneAlignTop DUT (
    .clk(clk),
    .rstN(rstN),
    .inValid(inValid),
    .inData(inData),
    .right(right),
    .rotate(rotate),
    .inKeep(inKeep),
    .drain(drain),
    .outValid(outValid),
    .outData(outData),
    .overflow(overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // One step per drain bit taken
  function automatic logic nextDrainBit();
    lfsrState = lfsrStep(lfsrState);
    return lfsrState[0];
  endfunction

  function automatic wordT field(input int idx, input int col);
    return vecMem[idx*VecFields + col];
  endfunction

  // Lines are counted up to the first tag that was never loaded
  function automatic int countVectors();
    int n;
    n = 0;
    while (n < MaxVectors && !$isunknown(vecMem[n*VecFields])) begin
      n++;
    end
    return n;
  endfunction

  task automatic checkWord(input string name, input wordT actual, input wordT expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // Starts and ends just after a falling edge
  task automatic applyReset();
    rstN = 1'b0;
    inValid = 1'b0;
    drain = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rstN = 1'b1;
  endtask

  // Drives one vector for a single cycle and queues its expected word
  task automatic sendItem(input int idx, input bit expectOut);
    inValid = 1'b1;
    inData = field(idx, 1);
    right = (field(idx, 2) != '0);
    rotate = rotateT'(field(idx, 3));
    inKeep = keepT'(field(idx, 4));
    if (expectOut) begin
      expQ.push_back(field(idx, 5));
    end
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic waitDrained(input int limit);
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      errorCount++;
      $display("%0d output words still missing after %0d cycles", expQ.size(), limit);
      expQ.delete();
    end
  endtask

  // Drain high and an empty buffer, so each word takes exactly three cycles
  task automatic runTimedPhase(input int tag);
    for (int idx = 0; idx < vectorCount; idx++) begin
      if (field(idx, 0) == wordT'(tag)) begin
        drain = 1'b1;
        sendItem(idx, 1'b1);
        checkFlag("outValid", outValid, 1'b0);
        @(negedge clk);
        checkFlag("outValid", outValid, 1'b0);
        @(negedge clk);
        checkFlag("outValid", outValid, 1'b1);
        waitDrained(8);
      end
    end
  endtask

  // Words beyond the buffer depth are dropped while drain is low
  task automatic runOverflowPhase(input int tag);
    int sent;
    sent = 0;
    drain = 1'b0;
    for (int idx = 0; idx < vectorCount; idx++) begin
      if (field(idx, 0) == wordT'(tag)) begin
        sendItem(idx, sent < FifoDepth);
        sent++;
      end
    end
    repeat (2) @(negedge clk);
    checkFlag("overflow", overflow, logic'(sent > FifoDepth));
    drain = 1'b1;
    waitDrained(4 * FifoDepth);
    // Dropped words would show up here as unexpected outputs
    repeat (4) @(negedge clk);
    checkFlag("overflow", overflow, logic'(sent > FifoDepth));
  endtask

  // Random drain, with at most FifoDepth words outstanding at any time
  task automatic runRandomPhase(input int tag);
    int idx;
    int waited;
    idx = 0;
    waited = 0;
    while (idx < vectorCount) begin
      if (field(idx, 0) != wordT'(tag)) begin
        idx++;
      end else begin
        drain = nextDrainBit();
        if (expQ.size() < FifoDepth) begin
          sendItem(idx, 1'b1);
          idx++;
        end else begin
          @(negedge clk);
        end
      end
    end
    while (expQ.size() != 0 && waited < 20 * FifoDepth) begin
      drain = nextDrainBit();
      @(negedge clk);
      waited++;
    end
    drain = 1'b1;
    waitDrained(8);
    checkFlag("overflow", overflow, 1'b0);
  endtask

  // Output monitor, sampled mid-cycle where outputs are steady
  always @(negedge clk) begin
    if (outValid === 1'b1) begin
      if (expQ.size() == 0) begin
        errorCount++;
        $display("Output word %h at %0t arrived with nothing outstanding", outData, $time);
      end else begin
        checkWord("outData", outData, expQ.pop_front());
      end
    end
  end

  // Time budget scales with the number of vectors
  initial begin
    wait (vectorCount > 0);
    #((vectorCount + 50) * ClkPeriod * 4);
    $display("Watchdog expired before the tests completed");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    inValid = 1'b0;
    inData = '0;
    right = 1'b0;
    rotate = '0;
    inKeep = '0;
    drain = 1'b0;
    lfsrState = 32'hf4d0_fc13;
    $readmemh("testbench/laneAlignVectors.txt", vecMem);
    vectorCount = countVectors();
    if (vectorCount == 0) begin
      errorCount++;
      $display("No vectors could be read from the vector file");
    end else begin
      applyReset();
      runTimedPhase(1);
      runTimedPhase(2);
      runOverflowPhase(3);
      // Fresh reset so that overflow starts low for the random stream
      applyReset();
      checkFlag("overflow", overflow, 1'b0);
      runRandomPhase(4);
      repeat (4) @(negedge clk);
      if (expQ.size() != 0) begin
        errorCount++;
        $display("%0d expected words never came out", expQ.size());
      end
    end
    errorCount += DUT.uBuffer.bufferChecks.failCount;
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/laneAlign_assertions.sv
////////////////////
// Lane buffer checks
// Occupancy, pop and overflow rules of the alignment buffer
////////////////////
`default_nettype none

module laneAlignBufferChecks (
  input logic clk,
  input logic rstN,
  input laneAlignPkg::countT count,
  input logic pop,
  input logic empty,
  input logic overflow
);
  timeunit 1ns;
  timeprecision 100ps;

  import laneAlignPkg::*;

  // Running total of failed assertions
  int failCount = 0;

  // The store never holds more than its depth
  occupancyBound: assert property (@(posedge clk) disable iff (!rstN)
    count <= countT'(FifoDepth))
    else begin
      failCount++;
      $error("Buffer occupancy %0d is above its depth", count);
    end

  // The emitter only pops a buffer that holds a word
  popNotEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
    else begin
      failCount++;
      $error("Pop issued while the buffer was empty");
    end

  // Overflow is sticky, only reset clears it
  overflowSticky: assert property (@(posedge clk)
    (rstN && $past(rstN) && $past(overflow)) |-> overflow)
    else begin
      failCount++;
      $error("Overflow fell while reset was released");
    end

  // Reset leaves the buffer empty
  emptyAfterReset: assert property (@(posedge clk) (rstN && !$past(rstN)) |-> empty)
    else begin
      failCount++;
      $error("Buffer not empty in the first cycle after reset");
    end

endmodule

bind laneBuffer laneAlignBufferChecks bufferChecks (
  .clk(clk),
  .rstN(rstN),
  .count(count),
  .pop(doPop),
  .empty(fifo.empty),
  .overflow(overflow)
);

`default_nettype wire

// File: verilog/laneAlignTop.sv
////////////////////
// Lane alignment top
// Rotator into buffer into emitter, three cycles input to output
////////////////////
`default_nettype none

module laneAlignTop (
  input logic clk,
  input logic rstN,
  input logic inValid,
  input laneAlignPkg::wordT inData,
  input logic right,
  input laneAlignPkg::rotateT rotate,
  input laneAlignPkg::keepT inKeep,
  input logic drain,
  output logic outValid,
  output laneAlignPkg::wordT outData,
  output logic overflow
);
  import laneAlignPkg::*;

  // Rotator to buffer, a strobe with its word and keep count
  logic rotValid;
  wordT rotData;
  keepT rotKeep;

  // Buffer to emitter
  laneFifoIf fifoBus ();

  // Stage 1, rotate and register
  laneRotator uRotator (
    .clk(clk),
    .rstN(rstN),
    .inValid(inValid),
    .inData(inData),
    .right(right),
    .rotate(rotate),
    .inKeep(inKeep),
    .rotValid(rotValid),
    .rotData(rotData),
    .rotKeep(rotKeep)
  );

  // Stage 2, hold up to four words
  laneBuffer uBuffer (
    .clk(clk),
    .rstN(rstN),
    .rotValid(rotValid),
    .rotData(rotData),
    .rotKeep(rotKeep),
    .fifo(fifoBus.bufferSide),
    .overflow(overflow)
  );

  // Stage 3, pop under drain and mask
  laneEmitter uEmitter (
    .clk(clk),
    .rstN(rstN),
    .drain(drain),
    .fifo(fifoBus.emitterSide),
    .outValid(outValid),
    .outData(outData)
  );

endmodule

`default_nettype wire

// File: verilog/laneEmitter.sv
////////////////////
// Lane emitter
// Drains the buffer and zeroes lanes at or above the keep count
////////////////////
`default_nettype none

module laneEmitter (
  input logic clk,
  input logic rstN,
  input logic drain,
  laneFifoIf.emitterSide fifo,
  output logic outValid,
  output laneAlignPkg::wordT outData
);
  import laneAlignPkg::*;

  // Head word after masking
  wordT maskedWord;

  // Pop whenever drain is high and there is something to take
  assign fifo.pop = drain && !fifo.empty;

  // Lane i survives only if i is below the keep count, so a keep of 0
  // clears the word and a keep of 8 passes it untouched
  for (genvar lane = 0; lane < NumSymbols; lane++) begin : genMask
    symbolT headLane;

    assign headLane = fifo.popData[lane*SymbolWidth +: SymbolWidth];

    assign maskedWord[lane*SymbolWidth +: SymbolWidth] =
      (keepT'(lane) < fifo.popKeep) ? headLane : '0;
  end

  // One outValid pulse per pop
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= fifo.pop;
    end
  end

  // Output word is captured on the popping edge and holds until the next pop
  always_ff @(posedge clk) begin
    if (fifo.pop) begin
      outData <= maskedWord;
    end
  end

endmodule

`default_nettype wire

// File: verilog/laneBuffer.sv
////////////////////
// Lane buffer
// Four-entry circular store of rotated words, sticky overflow on drop
////////////////////
`default_nettype none

module laneBuffer (
  input logic clk,
  input logic rstN,
  input logic rotValid,
  input laneAlignPkg::wordT rotData,
  input laneAlignPkg::keepT rotKeep,
  laneFifoIf.bufferSide fifo,
  output logic overflow
);
  import laneAlignPkg::*;

  // Storage for the words and their keep counts
  wordT dataMem [FifoDepth];
  keepT keepMem [FifoDepth];

  // Pointers wrap on their own since FifoDepth is a power of two
  ptrT wrPtr;
  ptrT rdPtr;
  // Number of words currently held
  countT count;

  logic full;
  logic doWrite;
  logic doPop;

  assign full = (count == countT'(FifoDepth));

  // A strobe into a full buffer is dropped, even if a pop
  // frees a slot on the same edge
  assign doWrite = rotValid && !full;

  // The emitter only pops while empty is low
  assign doPop = fifo.pop;

  // Head of the buffer is always on show
  assign fifo.popData = dataMem[rdPtr];
  assign fifo.popKeep = keepMem[rdPtr];
  assign fifo.empty = (count == '0);

  // Pointer and occupancy bookkeeping
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous write and pop leave the occupancy unchanged
      case ({doWrite, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage writes
  always_ff @(posedge clk) begin
    if (doWrite) begin
      dataMem[wrPtr] <= rotData;
      keepMem[wrPtr] <= rotKeep;
    end
  end

  // Overflow stays set from the first dropped word until reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      overflow <= 1'b0;
    end else if (rotValid && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/laneRotator.sv
////////////////////
// Lane rotator
// Registered barrel rotate of a word by whole symbols, left or right
////////////////////
`default_nettype none

module laneRotator (
  input logic clk,
  input logic rstN,
  input logic inValid,
  input laneAlignPkg::wordT inData,
  input logic right,
  input laneAlignPkg::rotateT rotate,
  input laneAlignPkg::keepT inKeep,
  output logic rotValid,
  output laneAlignPkg::wordT rotData,
  output laneAlignPkg::keepT rotKeep
);
  import laneAlignPkg::*;

  // Left rotation puts input lane i at output lane (i + R) mod 8
  // Right rotation puts input lane (i + R) mod 8 at output lane i
  // Both are served by one left-rotate network

  // Right by R equals left by NumSymbols - R
  // One extra bit holds the value 8
  logic [RotateWidth:0] invRotateExt;
  // Inverted amount folded back into range
  rotateT invRotate;
  // Amount actually applied by the left-rotate network
  rotateT leftAmount;

  assign invRotateExt = (RotateWidth + 1)'(NumSymbols) - {1'b0, rotate};

  // Dropping the top bit turns a left rotate by 8 into no rotation,
  // so a right rotate by zero stays zero
  assign invRotate = invRotateExt[RotateWidth-1:0];
  assign leftAmount = right ? invRotate : rotate;

  // Stage 0 is the raw input and the last stage is the rotated word
  wordT stages [RotateWidth+1];

  assign stages[0] = inData;

  // Each stage passes its input or rotates it left by 2^stage lanes
  // as the matching bit of the left amount selects
  for (genvar stage = 0; stage < RotateWidth; stage++) begin : genStages
    wordT stageRot;

    // The top lanes wrap around into the bottom of the word
    assign stageRot = {
      stages[stage][WordWidth-1-(SymbolWidth<<stage):0],
      stages[stage][WordWidth-1:WordWidth-(SymbolWidth<<stage)]
    };

    assign stages[stage+1] = leftAmount[stage] ? stageRot : stages[stage];
  end

  // The strobe follows inValid one cycle later
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rotValid <= 1'b0;
    end else begin
      rotValid <= inValid;
    end
  end

  // Word and keep count load only with an accepted input and hold between strobes
  always_ff @(posedge clk) begin
    if (inValid) begin
      rotData <= stages[RotateWidth];
      rotKeep <= inKeep;
    end
  end

endmodule

`default_nettype wire

// File: verilog/laneFifoIf.sv
////////////////////
// Buffer to emitter link
// Head entry, empty level and pop strobe
////////////////////
`default_nettype none

interface laneFifoIf;
  import laneAlignPkg::*;

  // Head word and its keep count, valid whenever empty is low
  wordT popData;
  keepT popKeep;
  // High while the buffer holds no words
  logic empty;
  // One-cycle strobe, the head is removed on the edge that samples it
  logic pop;

  // The buffer presents its head and takes pops
  modport bufferSide (
    output popData,
    output popKeep,
    output empty,
    input pop
  );

  // The emitter reads the head and issues pops
  modport emitterSide (
    input popData,
    input popKeep,
    input empty,
    output pop
  );

endinterface

`default_nettype wire

// File: verilog/laneAlignPkg.sv
////////////////////
// Lane alignment package
// Sizes and vector types shared by the rotator, buffer and emitter
////////////////////
`default_nettype none

package laneAlignPkg;

  // Number of byte lanes in one data word
  localparam int NumSymbols = 8;
  // Bits carried by one lane
  localparam int SymbolWidth = 8;
  // Entries held by the alignment buffer
  localparam int FifoDepth = 4;

  // Derived widths; rotate amounts never exceed NumSymbols-1,
  // so no modulo step is needed anywhere
  localparam int WordWidth = NumSymbols * SymbolWidth;
  localparam int RotateWidth = $clog2(NumSymbols);
  // Keep count runs from 0 to NumSymbols inclusive
  localparam int KeepWidth = $clog2(NumSymbols + 1);
  localparam int PtrWidth = $clog2(FifoDepth);
  // Occupancy runs from 0 to FifoDepth inclusive
  localparam int CountWidth = $clog2(FifoDepth + 1);

  // One lane
  typedef logic [SymbolWidth-1:0] symbolT;
  // Full word, lane 0 sits in the low byte
  typedef logic [WordWidth-1:0] wordT;
  // Rotate amount in whole lanes
  typedef logic [RotateWidth-1:0] rotateT;
  // Count of valid low lanes
  typedef logic [KeepWidth-1:0] keepT;
  // Buffer slot index
  typedef logic [PtrWidth-1:0] ptrT;
  // Buffer occupancy
  typedef logic [CountWidth-1:0] countT;

endpackage

`default_nettype wire
